// ==== verilog/pool_cfg_pkg.sv ====
/* software register map, control and status bit positions,
   and the width of one memory read answer */
`default_nettype none

package pool_cfg_pkg;

	localparam int APB_ADDR_WIDTH = 8; // byte offsets into the register block

	// register offsets
	localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h00; // go bit, reads back 0
	localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h04; // busy and done flags
	localparam logic [APB_ADDR_WIDTH-1:0] REG_SRC    = 8'h08; // picture base address
	localparam logic [APB_ADDR_WIDTH-1:0] REG_DST    = 8'h0C; // result base address

	// CTRL bits
	localparam int CTRL_GO = 0; // write 1 to start a run

	// STATUS bits
	localparam int STAT_BUSY = 0; // run in progress
	localparam int STAT_DONE = 1; // last run finished

	// pixels returned by one read
	localparam int LINE_BYTES = 8;

endpackage

`default_nettype wire

// ==== verilog/pool_mem_pkg.sv ====
/* packed structs for the memory read and write channels
   and for one window result */
`default_nettype none

package pool_mem_pkg;

	localparam int MEM_ADDR_WIDTH = 19; // byte address

	typedef logic [7:0] pixel_t; // unsigned 8-bit pixel

	// read request, held until the answer
	typedef struct packed {
		logic                      valid;
		logic [MEM_ADDR_WIDTH-1:0] addr; // address of the first pixel
	} rd_req_t;

	// read answer, one-cycle pulse
	typedef struct packed {
		logic                                  valid;
		pixel_t [pool_cfg_pkg::LINE_BYTES-1:0] data; // data[0] at the requested address
	} rd_rsp_t;

	// write request, held until the ack
	typedef struct packed {
		logic                      valid;
		logic [MEM_ADDR_WIDTH-1:0] addr;   // word address, multiple of 4
		logic [31:0]               data;   // result m in byte m
		logic [2:0]                nbytes; // 1 to 4 valid bytes
	} wr_req_t;

	// max of one window
	typedef struct packed {
		logic   valid;
		pixel_t pmax; // window maximum
		logic   last; // final window of the picture
	} win_result_t;

endpackage

`default_nettype wire

// ==== verilog/pool_apb_regs.sv ====
/* APB register block: source and destination addresses, go pulse, busy and done */
`default_nettype none

module pool_apb_regs (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic [pool_cfg_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  logic                                    psel,
	input  logic                                    penable,
	input  logic                                    pwrite,
	input  logic [31:0]                             pwdata,
	output logic [31:0]                             prdata,
	output logic                                    pready,
	input  logic                                    run_done,  // ack of the final word
	output logic                                    start,     // one-cycle run start
	output logic [pool_mem_pkg::MEM_ADDR_WIDTH-1:0] src_addr,
	output logic [pool_mem_pkg::MEM_ADDR_WIDTH-1:0] dst_addr
);

	logic busy;  // run in progress
	logic done;  // set by run_done, cleared by start
	logic wr_en; // write in ACCESS phase
	logic go;    // accepted go write

	assign pready = 1'b1; // no wait states
	assign wr_en  = psel & penable & pwrite;
	assign go     = wr_en && (paddr == pool_cfg_pkg::REG_CTRL)
		&& pwdata[pool_cfg_pkg::CTRL_GO] && !busy; // ignored while busy

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			start    <= 1'b0;
			busy     <= 1'b0;
			done     <= 1'b0;
			src_addr <= '0;
			dst_addr <= '0;
		end
		else
		begin
			start <= go; // pulse in the cycle after the write
			if (go)
			begin
				busy <= 1'b1; // visible together with start
				done <= 1'b0;
			end
			else if (run_done)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (wr_en && !busy && paddr == pool_cfg_pkg::REG_SRC)
				src_addr <= pwdata[pool_mem_pkg::MEM_ADDR_WIDTH-1:0]; // locked during a run
			if (wr_en && !busy && paddr == pool_cfg_pkg::REG_DST)
				dst_addr <= pwdata[pool_mem_pkg::MEM_ADDR_WIDTH-1:0];
		end
	end

	// read mux, unmapped offsets read 0
	always_comb
	begin
		prdata = '0;
		case (paddr)
			pool_cfg_pkg::REG_STATUS:
			begin
				prdata[pool_cfg_pkg::STAT_BUSY] = busy;
				prdata[pool_cfg_pkg::STAT_DONE] = done;
			end
			pool_cfg_pkg::REG_SRC: prdata[pool_mem_pkg::MEM_ADDR_WIDTH-1:0] = src_addr;
			pool_cfg_pkg::REG_DST: prdata[pool_mem_pkg::MEM_ADDR_WIDTH-1:0] = dst_addr;
			default: prdata = '0; // CTRL go bit reads back 0
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/pool_window_walker.sv ====
/* window walker: steps the windows in row-major order,
   issues one line read at a time and forwards each answer with its flags */
`default_nettype none

module pool_window_walker #(
	parameter int PIC_ROWS = 8,
	parameter int PIC_COLS = 8,
	parameter int WIN      = 2
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    start,
	input  logic [pool_mem_pkg::MEM_ADDR_WIDTH-1:0] src_addr,
	output pool_mem_pkg::rd_req_t                   rd_req,
	input  pool_mem_pkg::rd_rsp_t                   rd_rsp,
	input  logic                                    line_ready, // max unit can take a line
	output logic                                    line_valid,
	output pool_mem_pkg::pixel_t [pool_cfg_pkg::LINE_BYTES-1:0] line_data,
	output logic                                    line_first,
	output logic                                    line_last_in_win,
	output logic                                    line_last_in_pic
);

	localparam int AW   = pool_mem_pkg::MEM_ADDR_WIDTH;
	localparam int IMAX = PIC_ROWS - WIN; // last window row
	localparam int JMAX = PIC_COLS - WIN; // last window column
	localparam int I_W  = $clog2(PIC_ROWS);
	localparam int J_W  = $clog2(PIC_COLS);
	localparam int K_W  = $clog2(WIN);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE, // wait for line_ready
		S_WAIT,  // read outstanding
		S_ADV    // step counters and address
	} state_t;

	state_t         state;
	logic [K_W-1:0] k_cnt;     // line within the window
	logic [J_W-1:0] j_cnt;     // window column
	logic [I_W-1:0] i_cnt;     // window row
	logic [AW-1:0]  win_base;  // address of the window's top-left pixel
	logic [AW-1:0]  line_addr; // address of the next line read

	// flags follow the counters of the outstanding read
	assign line_first       = (k_cnt == '0);
	assign line_last_in_win = (k_cnt == K_W'(WIN - 1));
	assign line_last_in_pic = line_last_in_win && (i_cnt == I_W'(IMAX)) && (j_cnt == J_W'(JMAX));
	assign line_valid       = (state == S_WAIT) && rd_rsp.valid; // answer forwarded same cycle
	assign line_data        = rd_rsp.data;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= S_IDLE;
			rd_req    <= '0;
			k_cnt     <= '0;
			j_cnt     <= '0;
			i_cnt     <= '0;
			win_base  <= '0;
			line_addr <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						k_cnt     <= '0;
						j_cnt     <= '0;
						i_cnt     <= '0;
						win_base  <= src_addr;
						line_addr <= src_addr;
						rd_req    <= '{valid: 1'b1, addr: src_addr}; // first read without ISSUE
						state     <= S_WAIT;
					end
				end
				S_ISSUE:
				begin
					if (line_ready)
					begin
						rd_req <= '{valid: 1'b1, addr: line_addr};
						state  <= S_WAIT;
					end
				end
				S_WAIT:
				begin
					if (rd_rsp.valid)
					begin
						rd_req.valid <= 1'b0; // answer ends the transfer
						state        <= line_last_in_pic ? S_IDLE : S_ADV;
					end
				end
				S_ADV:
				begin
					if (!line_last_in_win)
					begin
						k_cnt     <= k_cnt + 1'b1;
						line_addr <= line_addr + AW'(PIC_COLS); // next picture row
					end
					else if (j_cnt != J_W'(JMAX))
					begin
						k_cnt     <= '0;
						j_cnt     <= j_cnt + 1'b1;
						win_base  <= win_base + 1'b1; // one column right
						line_addr <= win_base + 1'b1;
					end
					else
					begin
						k_cnt     <= '0;
						j_cnt     <= '0;
						i_cnt     <= i_cnt + 1'b1;
						win_base  <= win_base + AW'(WIN); // wrap to next window row
						line_addr <= win_base + AW'(WIN);
					end
					state <= S_ISSUE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pool_max_unit.sv ====
/* max unit: line maximum over WIN pixels, running maximum over WIN lines,
   result register held until the packer takes it */
`default_nettype none

module pool_max_unit #(
	parameter int WIN = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      line_valid,
	input  pool_mem_pkg::pixel_t [pool_cfg_pkg::LINE_BYTES-1:0] line_data,
	input  logic                      line_first,
	input  logic                      line_last_in_win,
	input  logic                      line_last_in_pic,
	output logic                      line_ready,
	output pool_mem_pkg::win_result_t win_result,
	input  logic                      ready // packer takes the result
);

	pool_mem_pkg::pixel_t line_max; // max of the first WIN bytes
	pool_mem_pkg::pixel_t acc;      // running max including this line
	pool_mem_pkg::pixel_t run_max;  // max of earlier lines of the window
	pool_mem_pkg::pixel_t res_max;
	logic                 res_valid;
	logic                 res_last;

	always_comb
	begin
		line_max = line_data[0];
		for (int b = 1; b < WIN; b++)
			if (line_data[b] > line_max)
				line_max = line_data[b];
	end

	assign acc        = (line_first || line_max > run_max) ? line_max : run_max; // restart on first line
	assign line_ready = !(res_valid && !ready); // stall while a result waits
	assign win_result = '{valid: res_valid, pmax: res_max, last: res_last};

	always_ff @(posedge clk)
	begin
		if (line_valid)
			run_max <= acc;
		if (line_valid && line_last_in_win)
		begin
			res_max  <= acc;
			res_last <= line_last_in_pic; // marks the end of the run
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else if (line_valid && line_last_in_win)
			res_valid <= 1'b1; // previous result already gone
		else if (ready)
			res_valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verilog/pool_result_packer.sv ====
/* result packer: four results per write word, early flush on the last result,
   run_done on the ack of the final word */
`default_nettype none

module pool_result_packer (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    start,
	input  logic [pool_mem_pkg::MEM_ADDR_WIDTH-1:0] dst_addr,
	input  pool_mem_pkg::win_result_t               win_result,
	output logic                                    ready,
	output pool_mem_pkg::wr_req_t                   wr_req,
	input  logic                                    wr_ack,
	output logic                                    run_done
);

	pool_mem_pkg::pixel_t [3:0]                  acc_data; // unused bytes stay 0
	logic [2:0]                                  acc_cnt;  // results collected
	logic                                        acc_last; // holds the final result
	logic [pool_mem_pkg::MEM_ADDR_WIDTH-3:0]     widx;     // output word index
	logic                                        wr_last;  // word in flight is the final one
	logic                                        flush_req;
	logic                                        slot_free;
	logic                                        flush;
	logic                                        take;

	assign flush_req = (acc_cnt == 3'd4) || acc_last;
	assign slot_free = !wr_req.valid || wr_ack;
	assign flush     = flush_req && slot_free;
	assign ready     = !flush_req || slot_free; // full buffer and busy write stall
	assign take      = win_result.valid && ready;
	assign run_done  = wr_req.valid && wr_ack && wr_last;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			acc_data <= '0;
			acc_cnt  <= '0;
			acc_last <= 1'b0;
			widx     <= '0;
			wr_req   <= '0;
			wr_last  <= 1'b0;
		end
		else
		begin
			if (wr_ack)
				wr_req.valid <= 1'b0;
			if (start)
			begin
				acc_data <= '0;
				acc_cnt  <= '0;
				acc_last <= 1'b0;
				widx     <= '0;
			end
			else
			begin
				if (flush)
				begin
					wr_req  <= '{valid: 1'b1, addr: dst_addr + {widx, 2'b00},
						data: acc_data, nbytes: acc_cnt};
					wr_last  <= acc_last;
					widx     <= widx + 1'b1;
					acc_data <= '0;
					acc_cnt  <= '0;
					acc_last <= 1'b0;
				end
				if (take)
				begin
					if (flush)
					begin
						acc_data <= {24'd0, win_result.pmax}; // first byte of a fresh word
						acc_cnt  <= 3'd1;
					end
					else
					begin
						acc_data[acc_cnt[1:0]] <= win_result.pmax; // result m in byte m
						acc_cnt                <= acc_cnt + 1'b1;
					end
					acc_last <= win_result.last;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pool_top.sv ====
/* max-pooling engine top: APB registers, window walker, max unit, result packer */
`default_nettype none

module pool_top #(
	parameter int PIC_ROWS = 8,
	parameter int PIC_COLS = 8,
	parameter int WIN      = 2 // 2 to LINE_BYTES
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic [pool_cfg_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  logic                                    psel,
	input  logic                                    penable,
	input  logic                                    pwrite,
	input  logic [31:0]                             pwdata,
	output logic [31:0]                             prdata,
	output logic                                    pready,
	output pool_mem_pkg::rd_req_t                   rd_req,
	input  pool_mem_pkg::rd_rsp_t                   rd_rsp,
	output pool_mem_pkg::wr_req_t                   wr_req,
	input  logic                                    wr_ack
);

	logic                                           start;
	logic                                           run_done;
	logic [pool_mem_pkg::MEM_ADDR_WIDTH-1:0]        src_addr;
	logic [pool_mem_pkg::MEM_ADDR_WIDTH-1:0]        dst_addr;
	logic                                           line_valid;
	pool_mem_pkg::pixel_t [pool_cfg_pkg::LINE_BYTES-1:0] line_data;
	logic                                           line_first;
	logic                                           line_last_in_win;
	logic                                           line_last_in_pic;
	logic                                           line_ready;
	pool_mem_pkg::win_result_t                      win_result;
	logic                                           res_ready; // packer back-pressure

	pool_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.run_done(run_done), .start(start), .src_addr(src_addr), .dst_addr(dst_addr)
	);

	pool_window_walker #(.PIC_ROWS(PIC_ROWS), .PIC_COLS(PIC_COLS), .WIN(WIN)) u_walker (
		.clk(clk), .rst_n(rst_n), .start(start), .src_addr(src_addr),
		.rd_req(rd_req), .rd_rsp(rd_rsp), .line_ready(line_ready),
		.line_valid(line_valid), .line_data(line_data), .line_first(line_first),
		.line_last_in_win(line_last_in_win), .line_last_in_pic(line_last_in_pic)
	);

	pool_max_unit #(.WIN(WIN)) u_max (
		.clk(clk), .rst_n(rst_n), .line_valid(line_valid), .line_data(line_data),
		.line_first(line_first), .line_last_in_win(line_last_in_win),
		.line_last_in_pic(line_last_in_pic), .line_ready(line_ready),
		.win_result(win_result), .ready(res_ready)
	);

	pool_result_packer u_packer (
		.clk(clk), .rst_n(rst_n), .start(start), .dst_addr(dst_addr),
		.win_result(win_result), .ready(res_ready), .wr_req(wr_req),
		.wr_ack(wr_ack), .run_done(run_done)
	);

endmodule

`default_nettype wire

// ==== dv/pool_mem_model.sv ====
/* testbench memory: byte array with read answers and write acks
   after LFSR-drawn delays, short or slow */
`default_nettype none

module pool_mem_model (
	input  logic                  clk,
	input  logic                  slow,   // delays of 0 to 31 cycles
	input  pool_mem_pkg::rd_req_t rd_req,
	output pool_mem_pkg::rd_rsp_t rd_rsp,
	input  pool_mem_pkg::wr_req_t wr_req,
	output logic                  wr_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int AW    = pool_mem_pkg::MEM_ADDR_WIDTH;
	localparam int DEPTH = 1 << AW;

	logic [7:0]  mem_bytes [0:DEPTH-1];
	logic [31:0] lfsr;    // delay source
	bit          rd_busy; // read accepted, answer pending
	bit          wr_busy;
	int          rd_cnt;  // cycles left before the answer
	int          wr_cnt;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	// one LFSR step per delay bit
	task automatic draw_delay(output int d);
		logic [4:0] v;
		int         nbits;
		v     = '0;
		nbits = slow ? 5 : 3;
		for (int b = 0; b < nbits; b++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[3:0], lfsr[0]};
		end
		d = int'(v);
	endtask

	task automatic store_byte(input logic [AW-1:0] a, input logic [7:0] v);
		mem_bytes[a] = v; // picture load from the testbench
	endtask

	initial
	begin
		logic [AW-1:0] a;
		lfsr    = 32'h4b68cfe7;
		rd_rsp  = '0;
		wr_ack  = 1'b0;
		rd_busy = 0;
		wr_busy = 0;
		rd_cnt  = 0;
		wr_cnt  = 0;
		for (int i = 0; i < DEPTH; i++)
		begin
			a            = AW'(i);
			mem_bytes[i] = a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ 8'h5a; // whole-address fill
		end
		forever
		begin
			@(posedge clk);
			#1;
			rd_rsp.valid = 1'b0; // answers are one-cycle pulses
			wr_ack       = 1'b0;
			if (!rd_busy && rd_req.valid)
			begin
				rd_busy = 1;
				draw_delay(rd_cnt);
			end
			if (rd_busy && rd_cnt == 0)
			begin
				for (int b = 0; b < pool_cfg_pkg::LINE_BYTES; b++)
				begin
					a                = rd_req.addr + AW'(b);
					rd_rsp.data[b]   = mem_bytes[a]; // byte 0 at the request address
				end
				rd_rsp.valid = 1'b1;
				rd_busy      = 0;
			end
			else if (rd_busy)
				rd_cnt--;
			if (!wr_busy && wr_req.valid)
			begin
				wr_busy = 1;
				draw_delay(wr_cnt);
			end
			if (wr_busy && wr_cnt == 0)
			begin
				for (int m = 0; m < int'(wr_req.nbytes); m++)
				begin
					a            = wr_req.addr + AW'(m);
					mem_bytes[a] = wr_req.data[8*m +: 8]; // only the counted bytes
				end
				wr_ack  = 1'b1;
				wr_busy = 0;
			end
			else if (wr_busy)
				wr_cnt--;
		end
	end

endmodule

`default_nettype wire

// ==== dv/pool_tb.sv ====
/* testbench for the max-pooling engine: clock, reset, APB tasks,
   reference pooling function, write checker and timeout */
`default_nettype none

module pool_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS       = 8;
	localparam int COLS       = 8;
	localparam int WIN        = 2;
	localparam int WCOLS      = COLS - WIN + 1;           // windows per row
	localparam int N_RES      = (ROWS - WIN + 1) * WCOLS; // 49 results
	localparam int N_WORDS    = (N_RES + 3) / 4;          // 12 full, 1 partial
	localparam int MAX_CYCLES = 20000;                    // four slow runs with margin
	localparam int AW         = pool_mem_pkg::MEM_ADDR_WIDTH;

	logic                                    clk;
	logic                                    rst_n;
	logic [pool_cfg_pkg::APB_ADDR_WIDTH-1:0] paddr;
	logic                                    psel;
	logic                                    penable;
	logic                                    pwrite;
	logic [31:0]                             pwdata;
	logic [31:0]                             prdata;
	logic                                    pready;
	pool_mem_pkg::rd_req_t                   rd_req;
	pool_mem_pkg::rd_rsp_t                   rd_rsp;
	pool_mem_pkg::wr_req_t                   wr_req;
	logic                                    wr_ack;
	logic                                    slow; // long memory delays

	int            errors;
	int            writes_checked;
	int            words_seen; // words of the current run
	int            cycles;
	string         test_name;
	logic [31:0]   rnd;        // picture LFSR state
	logic [AW-1:0] exp_dst;
	logic [7:0]    pic [0:ROWS*COLS-1]; // current picture, row-major

	pool_top #(.PIC_ROWS(ROWS), .PIC_COLS(COLS), .WIN(WIN)) uut (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.rd_req(rd_req), .rd_rsp(rd_rsp), .wr_req(wr_req), .wr_ack(wr_ack)
	);

	pool_mem_model mem (
		.clk(clk), .slow(slow), .rd_req(rd_req), .rd_rsp(rd_rsp),
		.wr_req(wr_req), .wr_ack(wr_ack)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic random_byte(output logic [7:0] v);
		v = '0;
		for (int b = 0; b < 8; b++)
		begin
			rnd = lfsr_step(rnd); // one step per bit
			v   = {v[6:0], rnd[0]};
		end
	endtask

	// expected word n: window maxima 4n..4n+3, zero past the last result
	function automatic logic [31:0] pooled_word(input int n);
		logic [31:0] w;
		logic [7:0]  m;
		int          r;
		w = '0;
		for (int s = 0; s < 4; s++)
		begin
			r = 4 * n + s;
			m = 8'd0;
			if (r < N_RES)
				for (int k = 0; k < WIN; k++)
					for (int c = 0; c < WIN; c++)
						if (pic[(r / WCOLS + k) * COLS + r % WCOLS + c] > m)
							m = pic[(r / WCOLS + k) * COLS + r % WCOLS + c];
			w[8*s +: 8] = m;
		end
		return w;
	endfunction

	function automatic int word_bytes(input int n);
		return (N_RES - 4 * n >= 4) ? 4 : N_RES - 4 * n; // results left in the last word
	endfunction

	task automatic load_picture(input logic [AW-1:0] src);
		logic [7:0] v;
		for (int p = 0; p < ROWS * COLS; p++)
		begin
			random_byte(v);
			pic[p] = v;
			mem.store_byte(src + AW'(p), v);
		end
	endtask

	task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		paddr   = addr; // SETUP
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1; // ACCESS
		@(negedge clk);
		expect_equal("pready", 32'h1, 32'(pready)); // no wait states
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		data = prdata; // stable through the ACCESS cycle
		expect_equal("pready", 32'h1, 32'(pready));
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_quiet(input int n);
		for (int c = 0; c < n; c++)
		begin
			@(negedge clk);
			if (rd_req.valid || wr_req.valid)
			begin
				errors++;
				$display("%s: memory request seen while the engine should be idle", test_name);
			end
		end
	endtask

	task automatic run_picture(input string name, input logic [AW-1:0] src,
		input logic [AW-1:0] dst, input bit slow_mode, input bit new_pic);
		logic [31:0] rd;
		test_name = name;
		slow      = slow_mode;
		if (new_pic)
			load_picture(src);
		apb_write(pool_cfg_pkg::REG_SRC, 32'(src));
		apb_write(pool_cfg_pkg::REG_DST, 32'(dst));
		apb_read(pool_cfg_pkg::REG_SRC, rd);
		expect_equal("src readback", 32'(src), rd);
		apb_read(pool_cfg_pkg::REG_DST, rd);
		expect_equal("dst readback", 32'(dst), rd);
		exp_dst    = dst;
		words_seen = 0;
		apb_write(pool_cfg_pkg::REG_CTRL, 32'h1);
		apb_read(pool_cfg_pkg::REG_STATUS, rd);
		expect_equal("status in run", 32'h1, rd); // busy set, done cleared
		apb_write(pool_cfg_pkg::REG_CTRL, 32'h1); // go while busy, no second run
		apb_write(pool_cfg_pkg::REG_SRC, 32'(src ^ 19'h0f0f0));
		apb_write(pool_cfg_pkg::REG_DST, 32'(dst ^ 19'h00ff0));
		apb_read(pool_cfg_pkg::REG_SRC, rd);
		expect_equal("src locked", 32'(src), rd);
		apb_read(pool_cfg_pkg::REG_DST, rd);
		expect_equal("dst locked", 32'(dst), rd);
		rd = '0;
		while (!rd[pool_cfg_pkg::STAT_DONE])
			apb_read(pool_cfg_pkg::REG_STATUS, rd); // timeout process bounds this
		expect_equal("status after run", 32'h2, rd);
		if (words_seen != N_WORDS)
		begin
			errors++;
			$display("%s: %0d words written, %0d expected", test_name, words_seen, N_WORDS);
		end
		check_quiet(40); // a queued go would show up here
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// each acked write against the reference
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (wr_req.valid && wr_ack)
			begin
				if (words_seen >= N_WORDS)
				begin
					errors++;
					$display("%s: write beyond the %0d expected words", test_name, N_WORDS);
				end
				else
				begin
					if (wr_req.addr !== exp_dst + AW'(4 * words_seen))
					begin
						errors++;
						$display("FAIL %s addr word %0d: expected %h, actual %h", test_name,
							words_seen, exp_dst + AW'(4 * words_seen), wr_req.addr);
					end
					if (wr_req.data !== pooled_word(words_seen))
					begin
						errors++;
						$display("FAIL %s data word %0d: expected %h, actual %h", test_name,
							words_seen, pooled_word(words_seen), wr_req.data);
					end
					if (wr_req.nbytes !== 3'(word_bytes(words_seen)))
					begin
						errors++;
						$display("FAIL %s nbytes word %0d: expected %0d, actual %0d", test_name,
							words_seen, word_bytes(words_seen), wr_req.nbytes);
					end
				end
				words_seen++;
				writes_checked++;
			end
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: engine did not finish within %0d cycles", MAX_CYCLES);
		$display("errors: %0d, writes checked: %0d", errors, writes_checked);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] rd;
		paddr          = '0;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		pwdata         = '0;
		slow           = 1'b0;
		rst_n          = 1'b0;
		errors         = 0;
		writes_checked = 0;
		words_seen     = 0;
		exp_dst        = '0;
		rnd            = 32'h4b68cfe7;
		test_name      = "reset";
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		apb_read(pool_cfg_pkg::REG_STATUS, rd);
		expect_equal("status", 32'h0, rd);
		check_quiet(10); // nothing before go
		run_picture("fast_run", 19'h00100, 19'h04000, 1'b0, 1'b1);
		run_picture("slow_run", 19'h00100, 19'h04000, 1'b1, 1'b0); // same picture
		run_picture("second_run", 19'h12345, 19'h7ff00, 1'b0, 1'b1);
		run_picture("second_slow_run", 19'h20007, 19'h3c000, 1'b1, 1'b1);
		$display("errors: %0d, writes checked: %0d", errors, writes_checked);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/pool_cfg_pkg.sv
verilog/pool_mem_pkg.sv
verilog/pool_apb_regs.sv
verilog/pool_window_walker.sv
verilog/pool_max_unit.sv
verilog/pool_result_packer.sv
verilog/pool_top.sv
dv/pool_mem_model.sv
dv/pool_tb.sv
